/* fpu_defines.svh */
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// width of the tag the core attaches to a request
`define FPU_TAG_W 4

// request queue depth, also the core's starting credit count
`define FPU_REQ_DEPTH 4

// result queue depth
`define FPU_RES_DEPTH 2

// result slots owned by the writeback side
`define FPU_SINK_CREDITS 2

`endif

/* fpu_pkg.sv */
`include "fpu_defines.svh"

package fpu_pkg;

  // ieee single precision word
  typedef logic [31:0] fp_word_t;

  typedef logic [`FPU_TAG_W-1:0] fp_tag_t;

  typedef enum logic [2:0] {
    OP_DIV   = 3'd0,
    OP_SGNJ  = 3'd1,
    OP_SGNJN = 3'd2,
    OP_SGNJX = 3'd3,
    OP_MIN   = 3'd4,
    OP_MAX   = 3'd5
  } fp_op_e;

  // request queue entry
  typedef struct packed {
    fp_op_e   op;
    fp_tag_t  tag;
    fp_word_t rs1;
    fp_word_t rs2;
  } fp_req_t;

  // result queue entry
  typedef struct packed {
    fp_tag_t  tag;
    fp_word_t rd;
  } fp_res_t;

endpackage

/* fdiv.sv */
module fdiv (
  input  fpu_pkg::fp_word_t rs1,
  input  fpu_pkg::fp_word_t rs2,
  output fpu_pkg::fp_word_t rd
);

  // leading zero count, 48 when v is all zero
  function automatic logic [5:0] lead_zeros(input logic [47:0] v);
    logic [5:0] n;
    n = 6'd48;
    for (int i = 0; i < 48; i++) begin
      if (v[i]) n = 6'(47 - i);
    end
    return n;
  endfunction

  logic              s1;
  logic              s2;
  logic              sy;
  logic [7:0]        e1;
  logic [7:0]        e2;
  logic [22:0]       m1;
  logic [22:0]       m2;
  logic [23:0]       m1a;
  logic [23:0]       m2a;
  logic [23:0]       m1n;
  logic [8:0]        e1a;
  logic [8:0]        e2a;
  logic [4:0]        te;
  logic [47:0]       quo;
  logic [5:0]        se;
  logic [8:0]        eyd;
  logic [8:0]        eyd_rev;
  logic signed [9:0] eyff;
  logic signed [9:0] eyf;
  logic [9:0]        sh_sub;
  logic [9:0]        sh_rev;
  logic              ovf;
  logic [7:0]        eyr;
  logic [7:0]        ey;
  logic [22:0]       my;
  logic [47:0]       myf;
  logic              zero1;
  logic              zero2;
  logic              inf1;
  logic              inf2;

  assign s1 = rs1[31];
  assign s2 = rs2[31];
  assign e1 = rs1[30:23];
  assign e2 = rs2[30:23];
  assign m1 = rs1[22:0];
  assign m2 = rs2[22:0];
  assign sy = s1 ^ s2;

  // subnormals run as exponent 1 without the hidden bit
  assign m1a = {|e1, m1};
  assign m2a = {|e2, m2};
  assign e1a = (e1 == 8'd0) ? 9'd1 : {1'b0, e1};
  assign e2a = (e2 == 8'd0) ? 9'd1 : {1'b0, e2};

  assign te  = 5'(lead_zeros({m1a, 24'hff_ffff})); // padding caps the count at 24
  assign m1n = m1a << te;

  assign quo = {m1n, 24'd0} / {24'd0, m2a};
  assign se  = lead_zeros(quo);

  assign eyd     = 9'd127 + e1a - e2a - {4'd0, te};
  assign eyd_rev = e2a + {4'd0, te} - e1a - 9'd127;
  assign eyff    = 10'd127 + {1'b0, e1a} - {1'b0, e2a} - {5'd0, te} - {4'd0, se};
  assign eyf     = eyff + 10'sd23;

  assign sh_sub = {5'd0, eyd[4:0]} - $unsigned(eyff);
  assign sh_rev = 10'd22 - {1'b0, eyd_rev}; // wraps high when result underflows

  assign ovf = (eyf >= 10'sd255);
  assign eyr = (eyf > 10'sd0) ? eyf[7:0] : 8'd0;

  // mantissa alignment, normal then the subnormal result paths
  always_comb begin
    if (eyff > 10'sd0) begin
      myf = quo << se;
    end else if (eyf > 10'sd0) begin
      myf = quo << sh_sub;
    end else if ((e1 == 8'd0) && (e2 == 8'd127)) begin
      myf = quo << (6'd23 - {1'b0, te});
    end else if (e1a + 9'd126 == e2a) begin
      myf = quo << 23;
    end else if ((e1 == 8'd0) && (({3'd0, te} + e2) == 8'd127)) begin
      myf = quo << 23;
    end else begin
      myf = quo << sh_rev;
    end
  end

  assign ey = ovf ? 8'hff : eyr;
  assign my = ovf ? 23'd0 : myf[46:24]; // truncated, no rounding

  assign zero1 = (e1 == 8'd0) && (m1 == 23'd0);
  assign zero2 = (e2 == 8'd0) && (m2 == 23'd0);
  assign inf1  = (e1 == 8'hff) && (m1 == 23'd0);
  assign inf2  = (e2 == 8'hff) && (m2 == 23'd0);

  always_comb begin
    if (zero1 && zero2) begin
      rd = 32'hffc0_0000;
    end else if (zero2) begin
      rd = {sy, 8'hff, 23'd0};
    end else if (inf1) begin
      rd = {sy, 8'hff, 23'd0};
    end else if (e1 == 8'hff) begin
      rd = {s1, 8'hff, 1'b1, m1[21:0]}; // quiet the nan
    end else if (inf2) begin
      rd = {sy, 31'd0};
    end else if (e2 == 8'hff) begin
      rd = {s2, 8'hff, 1'b1, m2[21:0]};
    end else if (zero1) begin
      rd = {sy, 31'd0};
    end else begin
      rd = {sy, ey, my};
    end
  end

endmodule

/* fp_sgnj_minmax.sv */
module fp_sgnj_minmax (
  input  fpu_pkg::fp_op_e   op,
  input  fpu_pkg::fp_word_t rs1,
  input  fpu_pkg::fp_word_t rs2,
  output fpu_pkg::fp_word_t rd
);

  localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;

  logic              nan1;
  logic              nan2;
  logic              rs1_lt;
  fpu_pkg::fp_word_t min_val;
  fpu_pkg::fp_word_t max_val;

  assign nan1 = (rs1[30:23] == 8'hff) && (rs1[22:0] != 23'd0);
  assign nan2 = (rs2[30:23] == 8'hff) && (rs2[22:0] != 23'd0);

  // sign magnitude compare, so -0 sorts below +0
  always_comb begin
    if (rs1[31] != rs2[31]) begin
      rs1_lt = rs1[31];
    end else if (rs1[31]) begin
      rs1_lt = rs1[30:0] > rs2[30:0];
    end else begin
      rs1_lt = rs1[30:0] < rs2[30:0];
    end
  end

  always_comb begin
    if (nan1 && nan2) begin
      min_val = CANON_NAN;
      max_val = CANON_NAN;
    end else if (nan1) begin
      min_val = rs2;
      max_val = rs2;
    end else if (nan2) begin
      min_val = rs1;
      max_val = rs1;
    end else begin
      min_val = rs1_lt ? rs1 : rs2;
      max_val = rs1_lt ? rs2 : rs1;
    end
  end

  always_comb begin
    case (op)
      fpu_pkg::OP_SGNJ:  rd = {rs2[31], rs1[30:0]};
      fpu_pkg::OP_SGNJN: rd = {~rs2[31], rs1[30:0]};
      fpu_pkg::OP_SGNJX: rd = {rs1[31] ^ rs2[31], rs1[30:0]};
      fpu_pkg::OP_MIN:   rd = min_val;
      fpu_pkg::OP_MAX:   rd = max_val;
      default:           rd = rs1; // divide goes through fdiv
    endcase
  end

endmodule

/* fp_credit_fifo.sv */
module fp_credit_fifo #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     pop_data,
  output logic not_empty,
  output logic not_full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;

  // wrap at DEPTH so non power of two depths work
  function automatic logic [AW-1:0] bump(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= bump(wr_ptr);
      if (pop) rd_ptr <= bump(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  assign pop_data  = mem[rd_ptr]; // head is visible without a pop
  assign not_empty = (count != '0);
  assign not_full  = (count != CW'(DEPTH));

endmodule

/* fp_exec_stage.sv */
module fp_exec_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_avail,
  input  fpu_pkg::fp_op_e   req_op,
  input  fpu_pkg::fp_tag_t  req_tag,
  input  fpu_pkg::fp_word_t rs1,
  input  fpu_pkg::fp_word_t rs2,
  output logic              req_pop,
  input  logic              res_room,
  output logic              res_push,
  output fpu_pkg::fp_tag_t  res_tag,
  output fpu_pkg::fp_word_t res_rd
);

  fpu_pkg::fp_word_t div_rd;
  fpu_pkg::fp_word_t sm_rd;
  fpu_pkg::fp_word_t sel_rd;

  fdiv u_fdiv (
    .rs1 (rs1),
    .rs2 (rs2),
    .rd  (div_rd)
  );

  fp_sgnj_minmax u_sgnj_minmax (
    .op  (req_op),
    .rs1 (rs1),
    .rs2 (rs2),
    .rd  (sm_rd)
  );

  // room already counts the result sitting in our register
  assign req_pop = req_avail && res_room;
  assign sel_rd  = (req_op == fpu_pkg::OP_DIV) ? div_rd : sm_rd;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_push <= 1'b0;
    end else begin
      res_push <= req_pop; // one cycle, pushed on the next edge
    end
  end

  always_ff @(posedge clk) begin
    if (req_pop) begin
      res_tag <= req_tag;
      res_rd  <= sel_rd;
    end
  end

endmodule

/* fp_result_port.sv */
`include "fpu_defines.svh"

module fp_result_port (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  fpu_pkg::fp_tag_t  push_tag,
  input  fpu_pkg::fp_word_t push_rd,
  output logic              room,
  input  logic              result_credit,
  output logic              result_valid,
  output fpu_pkg::fp_tag_t  result_tag,
  output fpu_pkg::fp_word_t rd
);

  localparam int CRED_W = $clog2(`FPU_SINK_CREDITS + 1);

  fpu_pkg::fp_res_t  in_res;
  fpu_pkg::fp_res_t  head;
  logic              send;
  logic              q_not_empty;
  logic              q_not_full;
  logic [CRED_W-1:0] credits;

  assign in_res = '{tag: push_tag, rd: push_rd};

  fp_credit_fifo #(
    .T     (fpu_pkg::fp_res_t),
    .DEPTH (`FPU_RES_DEPTH)
  ) u_res_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (in_res),
    .pop       (send),
    .pop_data  (head),
    .not_empty (q_not_empty),
    .not_full  (q_not_full)
  );

  assign send = q_not_empty && (credits != '0);

  // a pending push needs a second free slot unless the queue drains or is empty
  assign room = q_not_full && (!push || send || !q_not_empty);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= CRED_W'(`FPU_SINK_CREDITS);
    end else begin
      case ({result_credit, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits; // return and send cancel
      endcase
    end
  end

  // outputs straight off the queue head and credit registers
  assign result_valid = send;
  assign result_tag   = head.tag;
  assign rd           = head.rd;

endmodule

/* fpu_top.sv */
`include "fpu_defines.svh"

module fpu_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  fpu_pkg::fp_op_e       req_op,
  input  logic [`FPU_TAG_W-1:0] req_tag,
  input  fpu_pkg::fp_word_t     rs1,
  input  fpu_pkg::fp_word_t     rs2,
  output logic                  req_credit,
  input  logic                  result_credit,
  output logic                  result_valid,
  output logic [`FPU_TAG_W-1:0] result_tag,
  output fpu_pkg::fp_word_t     rd
);

  fpu_pkg::fp_req_t  req_in;
  fpu_pkg::fp_req_t  req_head;
  logic              req_avail;
  logic              req_pop;
  logic              res_room;
  logic              res_push;
  fpu_pkg::fp_tag_t  res_tag;
  fpu_pkg::fp_word_t res_rd;

  assign req_in     = '{op: req_op, tag: req_tag, rs1: rs1, rs2: rs2};
  assign req_credit = req_pop; // slot freed, credit back to the core

  fp_credit_fifo #(
    .T     (fpu_pkg::fp_req_t),
    .DEPTH (`FPU_REQ_DEPTH)
  ) u_req_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (req_valid),
    .push_data (req_in),
    .pop       (req_pop),
    .pop_data  (req_head),
    .not_empty (req_avail),
    .not_full  ()
  );

  fp_exec_stage u_exec (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_avail (req_avail),
    .req_op    (req_head.op),
    .req_tag   (req_head.tag),
    .rs1       (req_head.rs1),
    .rs2       (req_head.rs2),
    .req_pop   (req_pop),
    .res_room  (res_room),
    .res_push  (res_push),
    .res_tag   (res_tag),
    .res_rd    (res_rd)
  );

  fp_result_port u_res_port (
    .clk           (clk),
    .rst_n         (rst_n),
    .push          (res_push),
    .push_tag      (res_tag),
    .push_rd       (res_rd),
    .room          (res_room),
    .result_credit (result_credit),
    .result_valid  (result_valid),
    .result_tag    (result_tag),
    .rd            (rd)
  );

endmodule

/* fpu_tb.sv */
`include "fpu_defines.svh"

module fpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_VEC     = 27;
  localparam int TIMEOUT_CYC = 4000;
  localparam int TAIL_CYC    = 16; // idle cycles watched after the last result

  logic              clk = 1'b0;
  logic              rst_n;
  logic              req_valid;
  fpu_pkg::fp_op_e   req_op;
  fpu_pkg::fp_tag_t  req_tag;
  fpu_pkg::fp_word_t rs1;
  fpu_pkg::fp_word_t rs2;
  logic              req_credit;
  logic              result_credit;
  logic              result_valid;
  fpu_pkg::fp_tag_t  result_tag;
  fpu_pkg::fp_word_t rd;

  logic [31:0]       gold [5*NUM_VEC]; // op, tag, rs1, rs2, rd per vector
  fpu_pkg::fp_word_t sb_rd [NUM_VEC];
  fpu_pkg::fp_tag_t  sb_tag [NUM_VEC];

  integer seed;
  int     word_errs;
  int     tag_errs;
  int     proto_errs;
  int     req_cred;
  int     sink_cred;
  int     held;
  int     issued;
  int     recv_cnt;
  int     credit_pulses;
  int     tail;
  int     cyc;
  logic   withhold;

  always #20 clk = ~clk;

  fpu_top u_fpu_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_tag       (req_tag),
    .rs1           (rs1),
    .rs2           (rs2),
    .req_credit    (req_credit),
    .result_credit (result_credit),
    .result_valid  (result_valid),
    .result_tag    (result_tag),
    .rd            (rd)
  );

  task automatic check_word(input string name, input fpu_pkg::fp_word_t exp,
                            input fpu_pkg::fp_word_t act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      word_errs++;
    end
  endtask

  task automatic check_tag(input string name, input fpu_pkg::fp_tag_t exp,
                           input fpu_pkg::fp_tag_t act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      tag_errs++;
    end
  endtask

  task automatic protocol_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    proto_errs++;
  endtask

  initial begin
    seed          = 32'hfc2e_7c29;
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req_op        = fpu_pkg::OP_DIV;
    req_tag       = '0;
    rs1           = '0;
    rs2           = '0;
    result_credit = 1'b0;
    word_errs     = 0;
    tag_errs      = 0;
    proto_errs    = 0;
    req_cred      = `FPU_REQ_DEPTH;
    sink_cred     = `FPU_SINK_CREDITS;
    held          = 0;
    issued        = 0;
    recv_cnt      = 0;
    credit_pulses = 0;
    tail          = 0;
    for (int i = 0; i < 5*NUM_VEC; i++) gold[i] = 32'hbad0_0000 + 32'(i);
    $readmemh("fpu_golden.txt", gold);
    if (gold[5*(NUM_VEC-1)] > 32'd5) protocol_error("golden file holds too few vectors");

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    for (cyc = 0; cyc < TIMEOUT_CYC; cyc++) begin
      @(posedge clk); // outputs read here still hold their pre-edge values
      if (issued == 0 && (req_credit || result_valid)) begin
        protocol_error("req_credit or result_valid high before the first request");
      end
      if (req_credit) begin
        req_cred++;
        credit_pulses++;
        if (req_cred > `FPU_REQ_DEPTH) protocol_error("more request credits returned than spent");
      end
      if (result_valid) begin
        if (sink_cred == 0) protocol_error("result_valid high with no sink credit held");
        else sink_cred--;
        held++;
        if (held > `FPU_SINK_CREDITS) protocol_error("more results outstanding than sink slots");
        if (recv_cnt >= issued) begin
          protocol_error("result arrived with no request outstanding");
        end else begin
          check_tag($sformatf("vector %0d tag", recv_cnt), sb_tag[recv_cnt], result_tag);
          check_word($sformatf("vector %0d rd", recv_cnt), sb_rd[recv_cnt], rd);
          recv_cnt++;
        end
      end
      if (result_credit) sink_cred++;

      // long stretches with no credit back, random returns otherwise
      withhold = ((cyc % 64) >= 24) && ((cyc % 64) < 56);
      if (held > 0 && !withhold && (($random(seed) & 1) != 0)) begin
        result_credit <= 1'b1;
        held--;
      end else begin
        result_credit <= 1'b0;
      end

      if (issued < NUM_VEC && req_cred > 0 && cyc >= 3 && (($random(seed) & 3) != 0)) begin
        req_valid      <= 1'b1;
        req_op         <= fpu_pkg::fp_op_e'(gold[5*issued][2:0]);
        req_tag        <= gold[5*issued+1][`FPU_TAG_W-1:0];
        rs1            <= gold[5*issued+2];
        rs2            <= gold[5*issued+3];
        sb_tag[issued] = gold[5*issued+1][`FPU_TAG_W-1:0];
        sb_rd[issued]  = gold[5*issued+4];
        req_cred--;
        issued++;
      end else begin
        req_valid <= 1'b0;
      end

      if (recv_cnt == NUM_VEC) tail++;
      if (tail >= TAIL_CYC) break;
    end

    if (recv_cnt < NUM_VEC) begin
      $display("timed out after %0d cycles with %0d of %0d results received",
               TIMEOUT_CYC, recv_cnt, NUM_VEC);
      proto_errs++;
    end
    if (credit_pulses != issued) begin
      protocol_error($sformatf("saw %0d req_credit pulses for %0d requests",
                               credit_pulses, issued));
    end
    $display("errors: rd %0d, tag %0d, protocol %0d", word_errs, tag_errs, proto_errs);
    if (word_errs + tag_errs + proto_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* fpu_golden.txt */
// op tag rs1 rs2 rd, all hex; op 0 div, 1 sgnj, 2 sgnjn, 3 sgnjx, 4 min, 5 max
// divide results are truncated, not rounded
0 0 40c00000 40000000 40400000
0 1 3f800000 40400000 3eaaaaaa
0 2 c0f00000 40200000 c0400000
0 3 3f800000 41200000 3dcccccc
0 4 ff000000 3e800000 ff800000
0 5 00400000 3f000000 00800000
0 6 3f800000 00400000 7f000000
0 7 3f800000 7f000000 00400000
0 8 00000000 80000000 ffc00000
0 9 40400000 80000000 ff800000
0 a 7f800000 40000000 7f800000
0 b 7f800001 3f800000 7fc00001
0 c 3f800000 ffa00000 ffe00000
0 d c0000000 7f800000 80000000
0 e 80000000 c0400000 00000000
1 f 3f800000 c0000000 bf800000
2 0 bf800000 c0000000 3f800000
3 1 c0490fdb 3f800000 c0490fdb
1 2 7fc00000 80000000 ffc00000
4 3 00000000 80000000 80000000
5 4 80000000 00000000 00000000
4 5 3f800000 40000000 3f800000
5 6 bf800000 c0000000 bf800000
4 7 7fc00000 c0000000 c0000000
5 8 40400000 ff800001 40400000
4 9 7f800001 ffc00000 7fc00000
4 a ff800000 3f800000 ff800000

/* filelist.f */
+incdir+.
fpu_pkg.sv
fdiv.sv
fp_sgnj_minmax.sv
fp_credit_fifo.sv
fp_exec_stage.sv
fp_result_port.sv
fpu_top.sv
fpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fpu testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
  --top-module fpu_tb -Mdir obj_dir -o fpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/fpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Test OK$" sim.log; then
  exit 0
fi
exit 1
